// File: Bender.yml
package:
  name: tetris_vga

sources:
  - logic/tetris_pkg.sv
  - logic/button_debounce.sv
  - logic/drop_timer.sv
  - logic/playfield.sv
  - logic/vga_timing.sv
  - logic/pixel_render.sv
  - logic/tetris_top.sv
  - target: simulation
    files:
      - sim/tetris_props.sv
      - sim/tetris_tb.sv

// File: logic/button_debounce.sv
module button_debounce #(
  parameter int debounce_cycles = 4
) (
  input  logic clk,
  input  logic reset_i,
  input  logic btn_i,
  output logic level_o,
  output logic press_o
);

  localparam int cnt_w = $clog2(debounce_cycles + 1);

  // Consecutive cycles the raw input has disagreed with the level
  logic [cnt_w-1:0] diff_cnt;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      level_o  <= 1'b0;
      press_o  <= 1'b0;
      diff_cnt <= '0;
    end else begin
      press_o <= 1'b0;
      if (btn_i == level_o) begin
        // Bounce back to the old value, start counting again
        diff_cnt <= '0;
      end else if (diff_cnt == cnt_w'(debounce_cycles - 1)) begin
        // Held long enough, take the new value
        level_o  <= btn_i;
        // Pulse only on the rising flip
        press_o  <= btn_i;
        diff_cnt <= '0;
      end else begin
        diff_cnt <= diff_cnt + 1'b1;
      end
    end
  end

endmodule

// File: logic/drop_timer.sv
module drop_timer #(
  parameter int drop_frames_start = 48,
  parameter int drop_frames_min   = 4
) (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               frame_end_i,
  input  logic               fast_i,
  input  tetris_pkg::score_t score_i,
  output logic               tick_o
);

  // One bit wider than the score so the floor test cannot wrap
  logic [10:0] frame_cnt;
  logic [10:0] interval;
  logic [10:0] score_ext;
  logic        interval_done;

  assign score_ext = {1'b0, score_i};

  // Frames per gravity step
  always_comb begin
    if (fast_i) begin
      interval = 11'd1;
    end else if (score_ext + 11'(drop_frames_min) >= 11'(drop_frames_start)) begin
      // Floor reached
      interval = 11'(drop_frames_min);
    end else begin
      interval = 11'(drop_frames_start) - score_ext;
    end
  end

  // Greater-or-equal so a shrinking interval never strands the counter
  assign interval_done = (frame_cnt + 11'd1) >= interval;

  // Same cycle as the frame end that completes the interval
  assign tick_o = frame_end_i && interval_done;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      frame_cnt <= '0;
    end else if (frame_end_i) begin
      frame_cnt <= interval_done ? 11'd0 : frame_cnt + 11'd1;
    end
  end

endmodule

// File: logic/pixel_render.sv
module pixel_render #(
  parameter int cell_px = 16
) (
  input  logic             clk,
  input  logic             reset_i,
  input  logic [9:0]       x_i,
  input  logic [9:0]       y_i,
  input  logic             active_i,
  input  logic             hsync_i,
  input  logic             vsync_i,
  input  logic             piece_hit_i,
  input  logic             locked_hit_i,
  input  logic             gameover_i,
  output tetris_pkg::col_t query_col_o,
  output tetris_pkg::row_t query_row_o,
  output logic             red_o,
  output logic             green_o,
  output logic             blue_o,
  output logic             hsync_o,
  output logic             vsync_o
);

  // Full-width cell coordinate before truncation
  logic [9:0] cell_x;
  logic [9:0] cell_y;
  logic       off_board;
  tetris_pkg::color_t color_d;
  tetris_pkg::color_t color_q;

  assign cell_x      = x_i / 10'(cell_px);
  assign cell_y      = y_i / 10'(cell_px);
  assign query_col_o = tetris_pkg::col_t'(cell_x);
  assign query_row_o = tetris_pkg::row_t'(cell_y);
  assign off_board   = (cell_x >= 10'(tetris_pkg::board_cols))
                    || (cell_y >= 10'(tetris_pkg::board_rows));

  // Piece over locked cells over background
  always_comb begin
    if (!active_i || off_board) begin
      color_d = tetris_pkg::color_black;
    end else if (piece_hit_i) begin
      color_d = tetris_pkg::color_piece;
    end else if (locked_hit_i) begin
      color_d = gameover_i ? tetris_pkg::color_over : tetris_pkg::color_locked;
    end else begin
      color_d = tetris_pkg::color_black;
    end
  end

  // Syncs take the same one-cycle delay as the colour
  always_ff @(posedge clk) begin
    if (reset_i) begin
      color_q <= tetris_pkg::color_black;
      hsync_o <= 1'b1;
      vsync_o <= 1'b1;
    end else begin
      color_q <= color_d;
      hsync_o <= hsync_i;
      vsync_o <= vsync_i;
    end
  end

  assign red_o   = color_q[2];
  assign green_o = color_q[1];
  assign blue_o  = color_q[0];

endmodule

// File: logic/playfield.sv
module playfield (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               frame_end_i,
  input  logic               tick_i,
  input  logic               left_i,
  input  logic               right_i,
  input  logic               start_i,
  input  tetris_pkg::col_t   query_col_i,
  input  tetris_pkg::row_t   query_row_i,
  output logic               piece_hit_o,
  output logic               locked_hit_o,
  output tetris_pkg::score_t score_o,
  output logic               gameover_o
);

  localparam int cols = tetris_pkg::board_cols;
  localparam int rows = tetris_pkg::board_rows;
  localparam tetris_pkg::col_t spawn_col = 4'd4;

  // Locked cells, row 0 at the top
  tetris_pkg::row_bits_t board [rows];
  tetris_pkg::row_bits_t nxt_board [rows];
  // Top-left cell of the 2x2 piece
  tetris_pkg::col_t piece_col, nxt_col;
  tetris_pkg::row_t piece_row, nxt_row;
  tetris_pkg::game_state_t state, nxt_state;
  tetris_pkg::score_t score, nxt_score;
  // Requests held until the next frame end
  logic move_left, move_right, start_req;

  // ======================================
  // Request latches
  // ======================================
  always_ff @(posedge clk) begin
    if (reset_i) begin
      move_left  <= 1'b0;
      move_right <= 1'b0;
      start_req  <= 1'b0;
    end else begin
      // Consumed by the frame update
      if (frame_end_i) begin
        move_left  <= 1'b0;
        move_right <= 1'b0;
        start_req  <= 1'b0;
      end
      // Last press in a frame wins
      if (left_i) begin
        move_left  <= 1'b1;
        move_right <= 1'b0;
      end else if (right_i) begin
        move_left  <= 1'b0;
        move_right <= 1'b1;
      end
      if (start_i) start_req <= 1'b1;
    end
  end

  // ======================================
  // Frame update: start, move, gravity
  // ======================================
  always_comb begin
    int dst;
    tetris_pkg::score_t cleared;
    tetris_pkg::row_bits_t kept [rows];
    nxt_board = board;
    nxt_col   = piece_col;
    nxt_row   = piece_row;
    nxt_state = state;
    nxt_score = score;
    dst       = rows - 1;
    cleared   = '0;
    kept      = '{default: '0};
    // Fresh game from idle or over
    if (start_req && state != tetris_pkg::state_play) begin
      nxt_board = '{default: '0};
      nxt_score = '0;
      nxt_col   = spawn_col;
      nxt_row   = '0;
      nxt_state = tetris_pkg::state_play;
    end
    if (nxt_state == tetris_pkg::state_play) begin
      // Horizontal move, wall and neighbour checks
      if (move_left && nxt_col != '0 && !nxt_board[nxt_row][nxt_col - 1'b1]
          && !nxt_board[nxt_row + 1'b1][nxt_col - 1'b1]) begin
        nxt_col = nxt_col - 1'b1;
      end else if (move_right && nxt_col < tetris_pkg::col_t'(cols - 2)
          && !nxt_board[nxt_row][nxt_col + 2'd2]
          && !nxt_board[nxt_row + 1'b1][nxt_col + 2'd2]) begin
        nxt_col = nxt_col + 1'b1;
      end
      if (tick_i) begin
        if (nxt_row < tetris_pkg::row_t'(rows - 2)
            && !nxt_board[nxt_row + 2'd2][nxt_col]
            && !nxt_board[nxt_row + 2'd2][nxt_col + 1'b1]) begin
          nxt_row = nxt_row + 1'b1;
        end else begin
          // Lock all four cells
          nxt_board[nxt_row][nxt_col]                = 1'b1;
          nxt_board[nxt_row][nxt_col + 1'b1]         = 1'b1;
          nxt_board[nxt_row + 1'b1][nxt_col]         = 1'b1;
          nxt_board[nxt_row + 1'b1][nxt_col + 1'b1]  = 1'b1;
          // Bottom-up compaction, full rows dropped
          for (int src = rows - 1; src >= 0; src--) begin
            if (nxt_board[src] == '1) begin
              cleared = cleared + 1'b1;
            end else begin
              kept[dst] = nxt_board[src];
              dst       = dst - 1;
            end
          end
          nxt_board = kept;
          nxt_score = nxt_score + cleared;
          nxt_col   = spawn_col;
          nxt_row   = '0;
          // Spawn blocked
          if (kept[0][spawn_col] || kept[0][spawn_col + 1'b1]
              || kept[1][spawn_col] || kept[1][spawn_col + 1'b1]) begin
            nxt_state = tetris_pkg::state_over;
          end
        end
      end
    end
  end

  // Board only changes on the frame boundary
  always_ff @(posedge clk) begin
    if (reset_i) begin
      board     <= '{default: '0};
      piece_col <= spawn_col;
      piece_row <= '0;
      state     <= tetris_pkg::state_idle;
      score     <= '0;
    end else if (frame_end_i) begin
      board     <= nxt_board;
      piece_col <= nxt_col;
      piece_row <= nxt_row;
      state     <= nxt_state;
      score     <= nxt_score;
    end
  end

  // Cell lookup for the renderer, piece hidden outside play
  assign piece_hit_o = (state == tetris_pkg::state_play)
      && (query_col_i == piece_col || query_col_i == piece_col + 1'b1)
      && (query_row_i == piece_row || query_row_i == piece_row + 1'b1);
  assign locked_hit_o = (query_row_i < tetris_pkg::row_t'(rows))
      && (query_col_i < tetris_pkg::col_t'(cols))
      && board[query_row_i][query_col_i];

  assign score_o    = score;
  assign gameover_o = (state == tetris_pkg::state_over);

endmodule

// File: logic/tetris_pkg.sv
package tetris_pkg;

  // ======================================
  // Board geometry
  // ======================================
  localparam int board_cols = 10;
  localparam int board_rows = 20;

  // Cell indices
  typedef logic [3:0] col_t;
  typedef logic [4:0] row_t;

  // One bit per column, bit 0 is the left edge
  typedef logic [9:0] row_bits_t;

  // Total rows cleared since start
  typedef logic [9:0] score_t;

  // Packed as {red, green, blue}
  typedef logic [2:0] color_t;

  typedef enum logic [1:0] {
    state_idle,
    state_play,
    state_over
  } game_state_t;

  // ======================================
  // Palette
  // ======================================
  localparam color_t color_black  = 3'b000;
  localparam color_t color_piece  = 3'b011;
  localparam color_t color_locked = 3'b111;
  localparam color_t color_over   = 3'b100;

endpackage

// File: logic/tetris_top.sv
module tetris_top #(
  parameter int h_active          = 640,
  parameter int h_front           = 16,
  parameter int h_sync            = 96,
  parameter int h_back            = 48,
  parameter int v_active          = 480,
  parameter int v_front           = 10,
  parameter int v_sync            = 2,
  parameter int v_back            = 33,
  parameter int cell_px           = 16,
  // About 10 ms at 25 MHz
  parameter int debounce_cycles   = 250000,
  parameter int drop_frames_start = 48,
  parameter int drop_frames_min   = 4
) (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               left_btn_i,
  input  logic               right_btn_i,
  input  logic               drop_btn_i,
  input  logic               start_i,
  output logic               red_o,
  output logic               green_o,
  output logic               blue_o,
  output logic               hsync_o,
  output logic               vsync_o,
  output tetris_pkg::score_t score_o,
  output logic               gameover_o
);

  logic left_press, right_press, drop_level;
  logic [9:0] x, y;
  logic active, hsync, vsync, frame_end, tick;
  logic piece_hit, locked_hit;
  tetris_pkg::col_t query_col;
  tetris_pkg::row_t query_row;

  // ======================================
  // Buttons and gravity
  // ======================================
  button_debounce #(.debounce_cycles(debounce_cycles)) u_left (
    .clk(clk), .reset_i(reset_i), .btn_i(left_btn_i), .level_o(), .press_o(left_press)
  );
  button_debounce #(.debounce_cycles(debounce_cycles)) u_right (
    .clk(clk), .reset_i(reset_i), .btn_i(right_btn_i), .level_o(), .press_o(right_press)
  );
  // Drop acts as a held level
  button_debounce #(.debounce_cycles(debounce_cycles)) u_drop (
    .clk(clk), .reset_i(reset_i), .btn_i(drop_btn_i), .level_o(drop_level), .press_o()
  );

  drop_timer #(
    .drop_frames_start(drop_frames_start),
    .drop_frames_min(drop_frames_min)
  ) u_drop_timer (
    .clk(clk), .reset_i(reset_i), .frame_end_i(frame_end), .fast_i(drop_level),
    .score_i(score_o), .tick_o(tick)
  );

  playfield u_playfield (
    .clk(clk), .reset_i(reset_i), .frame_end_i(frame_end), .tick_i(tick),
    .left_i(left_press), .right_i(right_press), .start_i(start_i),
    .query_col_i(query_col), .query_row_i(query_row),
    .piece_hit_o(piece_hit), .locked_hit_o(locked_hit),
    .score_o(score_o), .gameover_o(gameover_o)
  );

  // ======================================
  // Raster
  // ======================================
  vga_timing #(
    .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
    .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
  ) u_vga_timing (
    .clk(clk), .reset_i(reset_i), .x_o(x), .y_o(y), .active_o(active),
    .hsync_o(hsync), .vsync_o(vsync), .frame_end_o(frame_end)
  );

  pixel_render #(.cell_px(cell_px)) u_pixel_render (
    .clk(clk), .reset_i(reset_i), .x_i(x), .y_i(y), .active_i(active),
    .hsync_i(hsync), .vsync_i(vsync), .piece_hit_i(piece_hit),
    .locked_hit_i(locked_hit), .gameover_i(gameover_o),
    .query_col_o(query_col), .query_row_o(query_row),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o)
  );

endmodule

// File: logic/vga_timing.sv
module vga_timing #(
  parameter int h_active = 640,
  parameter int h_front  = 16,
  parameter int h_sync   = 96,
  parameter int h_back   = 48,
  parameter int v_active = 480,
  parameter int v_front  = 10,
  parameter int v_sync   = 2,
  parameter int v_back   = 33
) (
  input  logic       clk,
  input  logic       reset_i,
  output logic [9:0] x_o,
  output logic [9:0] y_o,
  output logic       active_o,
  output logic       hsync_o,
  output logic       vsync_o,
  output logic       frame_end_o
);

  localparam int h_total      = h_active + h_front + h_sync + h_back;
  localparam int v_total      = v_active + v_front + v_sync + v_back;
  localparam int h_sync_start = h_active + h_front;
  localparam int v_sync_start = v_active + v_front;

  logic [9:0] h_cnt;
  logic [9:0] v_cnt;
  logic       h_last;
  logic       v_last;

  assign h_last = (h_cnt == 10'(h_total - 1));
  assign v_last = (v_cnt == 10'(v_total - 1));

  // Pixel counter, line counter advances on each wrap
  always_ff @(posedge clk) begin
    if (reset_i) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
      v_cnt <= v_last ? 10'd0 : v_cnt + 10'd1;
    end else begin
      h_cnt <= h_cnt + 10'd1;
    end
  end

  assign x_o      = h_cnt;
  assign y_o      = v_cnt;
  assign active_o = (h_cnt < 10'(h_active)) && (v_cnt < 10'(v_active));

  // Active low inside the sync windows
  assign hsync_o = !((h_cnt >= 10'(h_sync_start)) && (h_cnt < 10'(h_sync_start + h_sync)));
  assign vsync_o = !((v_cnt >= 10'(v_sync_start)) && (v_cnt < 10'(v_sync_start + v_sync)));

  // Last pixel of the last line
  assign frame_end_o = h_last && v_last;

endmodule

// File: sim/tetris_props.sv
module tetris_props (
  input logic                    clk,
  input logic                    reset_i,
  input logic                    frame_end_i,
  input logic                    start_req_i,
  input tetris_pkg::score_t      score_i,
  input tetris_pkg::game_state_t state_i
);

  // ========================================
  // Raster strobe
  // ========================================
  frame_end_single: assert property (@(posedge clk) disable iff (reset_i)
    frame_end_i |=> !frame_end_i)
    else $error("frame end strobe held for more than one cycle");

  // ========================================
  // Game rules
  // ========================================
  // Score only falls on a restart
  score_monotonic: assert property (@(posedge clk) disable iff (reset_i)
    (score_i < $past(score_i)) |-> $past(frame_end_i && start_req_i))
    else $error("score decreased without a start");

  // Over is sticky until start
  over_sticky: assert property (@(posedge clk) disable iff (reset_i)
    (state_i == tetris_pkg::state_over) && !(frame_end_i && start_req_i)
    |=> (state_i == tetris_pkg::state_over))
    else $error("left game over without a start");

endmodule

// File: sim/tetris_tb.sv
module tetris_tb;

  // ========================================
  // Tiny raster, 16 x 25 = 400 cycles
  // ========================================
  localparam int h_active          = 12;
  localparam int h_front           = 1;
  localparam int h_sync            = 2;
  localparam int h_back            = 1;
  localparam int v_active          = 22;
  localparam int v_front           = 1;
  localparam int v_sync            = 1;
  localparam int v_back            = 1;
  localparam int debounce_cycles   = 3;
  localparam int drop_frames_start = 4;
  localparam int drop_frames_min   = 1;
  localparam int h_total        = h_active + h_front + h_sync + h_back;
  localparam int v_total        = v_active + v_front + v_sync + v_back;
  localparam int frame_cycles   = h_total * v_total;
  localparam int run_frames     = 400;
  localparam int timeout_cycles = run_frames * frame_cycles + 100;

  logic clk;
  logic reset_i;
  logic left_btn_i, right_btn_i, drop_btn_i, start_i;
  logic red_o, green_o, blue_o, hsync_o, vsync_o;
  tetris_pkg::score_t score_o;
  logic gameover_o;

  // Reference model, index 0 left, 1 right, 2 drop
  logic [2:0] deb_level;
  logic [2:0] deb_press;
  int deb_count [3];
  int ref_h, ref_v;
  logic [2:0] ref_color;
  logic ref_hsync, ref_vsync;
  int ref_frames;
  logic ref_left, ref_right, ref_start;
  logic [9:0] ref_board [20];
  int ref_col, ref_row, ref_score;
  tetris_pkg::game_state_t ref_state;

  // Stimulus and bookkeeping
  logic [31:0] lfsr;
  int hold [3];
  logic [2:0] rand_level;
  int frame_no, max_score;
  int cycle_count = 0;
  logic over_seen;
  string test_name;

  tetris_top #(
    .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
    .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back),
    .cell_px(1), .debounce_cycles(debounce_cycles),
    .drop_frames_start(drop_frames_start), .drop_frames_min(drop_frames_min)
  ) dut (
    .clk(clk), .reset_i(reset_i), .left_btn_i(left_btn_i), .right_btn_i(right_btn_i),
    .drop_btn_i(drop_btn_i), .start_i(start_i), .red_o(red_o), .green_o(green_o),
    .blue_o(blue_o), .hsync_o(hsync_o), .vsync_o(vsync_o), .score_o(score_o),
    .gameover_o(gameover_o)
  );

  bind playfield tetris_props u_props (
    .clk(clk), .reset_i(reset_i), .frame_end_i(frame_end_i), .start_req_i(start_req),
    .score_i(score), .state_i(state)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // ========================================
  // Error reporting
  // ========================================
  task automatic flag_mismatch(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("FAILED %s, %s: expected %0h, actual %0h", test_name, what, expected, actual);
    $display("test failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(input string why);
    $display("ERROR in %s: %s", test_name, why);
    $display("test failed");
    $fatal(1, "run aborted");
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit
  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  // ========================================
  // Game model
  // ========================================
  function automatic logic occupied(input int r, input int c);
    return ref_board[r][c];
  endfunction

  task automatic reset_model();
    deb_level = '0;
    deb_press = '0;
    deb_count = '{0, 0, 0};
    ref_h     = 0;
    ref_v     = 0;
    ref_color = 3'b000;
    ref_hsync = 1'b1;
    ref_vsync = 1'b1;
    ref_frames = 0;
    ref_left  = 1'b0;
    ref_right = 1'b0;
    ref_start = 1'b0;
    ref_board = '{default: '0};
    ref_col   = 4;
    ref_row   = 0;
    ref_score = 0;
    ref_state = tetris_pkg::state_idle;
  endtask

  // Full rows vanish top-down, everything above slides one row
  task automatic clear_full_rows();
    for (int r = 0; r < 20; r++) begin
      if (ref_board[r] == 10'h3ff) begin
        for (int k = r; k > 0; k--) begin
          ref_board[k] = ref_board[k - 1];
        end
        ref_board[0] = '0;
        ref_score++;
      end
    end
  endtask

  task automatic update_frame(input logic tick);
    if (ref_start && ref_state != tetris_pkg::state_play) begin
      ref_board = '{default: '0};
      ref_score = 0;
      ref_col   = 4;
      ref_row   = 0;
      ref_state = tetris_pkg::state_play;
    end
    if (ref_state == tetris_pkg::state_play) begin
      if (ref_left && ref_col > 0 && !occupied(ref_row, ref_col - 1)
          && !occupied(ref_row + 1, ref_col - 1)) begin
        ref_col--;
      end else if (ref_right && ref_col < 8 && !occupied(ref_row, ref_col + 2)
          && !occupied(ref_row + 1, ref_col + 2)) begin
        ref_col++;
      end
      if (tick) begin
        if (ref_row < 18 && !occupied(ref_row + 2, ref_col)
            && !occupied(ref_row + 2, ref_col + 1)) begin
          ref_row++;
        end else begin
          // Lock, clear, respawn
          for (int dr = 0; dr < 2; dr++) begin
            for (int dc = 0; dc < 2; dc++) begin
              ref_board[ref_row + dr][ref_col + dc] = 1'b1;
            end
          end
          clear_full_rows();
          ref_col = 4;
          ref_row = 0;
          if (occupied(0, 4) || occupied(0, 5) || occupied(1, 4) || occupied(1, 5)) begin
            ref_state = tetris_pkg::state_over;
          end
        end
      end
    end
  endtask

  // One clock edge, all decisions from pre-edge state
  task automatic advance_model(input logic rst, input logic [2:0] btns, input logic start,
                               output logic frame_end);
    logic tick, active, on_board, piece;
    logic [2:0] color;
    int interval;
    frame_end = 1'b0;
    if (rst) begin
      reset_model();
    end else begin
      frame_end = (ref_h == h_total - 1) && (ref_v == v_total - 1);
      active    = (ref_h < h_active) && (ref_v < v_active);
      on_board  = (ref_h < 10) && (ref_v < 20);
      piece = (ref_state == tetris_pkg::state_play) && (ref_h >= ref_col)
          && (ref_h <= ref_col + 1) && (ref_v >= ref_row) && (ref_v <= ref_row + 1);
      color = tetris_pkg::color_black;
      if (active && on_board) begin
        if (piece) begin
          color = tetris_pkg::color_piece;
        end else if (ref_board[ref_v][ref_h]) begin
          color = (ref_state == tetris_pkg::state_over) ? tetris_pkg::color_over
                                                        : tetris_pkg::color_locked;
        end
      end
      // Gravity interval, held drop forces every frame
      interval = drop_frames_start - ref_score;
      if (interval < drop_frames_min) interval = drop_frames_min;
      if (deb_level[2]) interval = 1;
      tick = frame_end && (ref_frames + 1 >= interval);
      if (frame_end) begin
        update_frame(tick);
        ref_frames = tick ? 0 : ref_frames + 1;
        ref_left   = 1'b0;
        ref_right  = 1'b0;
        ref_start  = 1'b0;
      end
      // Latch presses, newest wins
      if (deb_press[0]) begin
        ref_left  = 1'b1;
        ref_right = 1'b0;
      end else if (deb_press[1]) begin
        ref_left  = 1'b0;
        ref_right = 1'b1;
      end
      if (start) ref_start = 1'b1;
      // Debounce, new level after debounce_cycles steady cycles
      for (int i = 0; i < 3; i++) begin
        deb_press[i] = 1'b0;
        if (btns[i] != deb_level[i]) begin
          deb_count[i]++;
          if (deb_count[i] == debounce_cycles) begin
            deb_level[i] = btns[i];
            deb_press[i] = btns[i];
            deb_count[i] = 0;
          end
        end else begin
          deb_count[i] = 0;
        end
      end
      // Render register and raster counters
      ref_color = color;
      ref_hsync = !(ref_h >= h_active + h_front && ref_h < h_active + h_front + h_sync);
      ref_vsync = !(ref_v >= v_active + v_front && ref_v < v_active + v_front + v_sync);
      if (ref_h == h_total - 1) begin
        ref_h = 0;
        ref_v = (ref_v == v_total - 1) ? 0 : ref_v + 1;
      end else begin
        ref_h++;
      end
    end
  endtask

  // ========================================
  // Stimulus and checks
  // ========================================
  // Leftmost empty column pair on the bottom row
  function automatic int steer_target();
    for (int c = 0; c < 10; c += 2) begin
      if (!ref_board[19][c]) return c;
    end
    return 0;
  endfunction

  task automatic choose_inputs();
    int pos;
    int target;
    int val;
    logic [2:0] btns;
    pos  = ref_v * h_total + ref_h;
    btns = 3'b000;
    if (frame_no < 130) begin
      // Fill the bottom rows pair by pair
      test_name = "directed row clear";
      target  = steer_target();
      btns[0] = (ref_state == tetris_pkg::state_play) && (ref_col > target) && (pos < 8);
      btns[1] = (ref_state == tetris_pkg::state_play) && (ref_col < target) && (pos < 8);
      // Fast drop until the first clear, then the score sets the pace
      btns[2] = (ref_score < 2);
    end else if (frame_no < 280) begin
      test_name = "stack to game over";
      btns[2]   = 1'b1;
    end else begin
      test_name = "random play";
      for (int i = 0; i < 3; i++) begin
        if (hold[i] == 0) begin
          take_bits(1, val);
          rand_level[i] = val[0];
          take_bits(4, val);
          hold[i] = val;
        end else begin
          hold[i]--;
        end
      end
      btns = rand_level;
    end
    left_btn_i  = btns[0];
    right_btn_i = btns[1];
    drop_btn_i  = btns[2];
    // Once per frame while idle or over
    start_i = (ref_state != tetris_pkg::state_play) && (pos == 100);
  endtask

  task automatic check_outputs();
    assert ({red_o, green_o, blue_o} === ref_color)
      else flag_mismatch("rgb", ref_color, {red_o, green_o, blue_o});
    assert (hsync_o === ref_hsync) else flag_mismatch("hsync", ref_hsync, hsync_o);
    assert (vsync_o === ref_vsync) else flag_mismatch("vsync", ref_vsync, vsync_o);
    assert (score_o === 10'(ref_score)) else flag_mismatch("score", ref_score, score_o);
    assert (gameover_o === (ref_state == tetris_pkg::state_over))
      else flag_mismatch("gameover", ref_state == tetris_pkg::state_over, gameover_o);
  endtask

  initial begin
    logic fe;
    reset_i     = 1'b1;
    left_btn_i  = 1'b0;
    right_btn_i = 1'b0;
    drop_btn_i  = 1'b0;
    start_i     = 1'b0;
    lfsr        = 32'hee33_5336;
    hold        = '{0, 0, 0};
    rand_level  = 3'b000;
    frame_no    = 0;
    max_score   = 0;
    over_seen   = 1'b0;
    test_name   = "reset";
    reset_model();
    repeat (5) begin
      @(posedge clk);
      #1;
      advance_model(1'b1, 3'b000, 1'b0, fe);
      check_outputs();
    end
    reset_i = 1'b0;
    // Quiet outputs straight out of reset
    assert ({red_o, green_o, blue_o} === 3'b000)
      else flag_mismatch("rgb after reset", 0, {red_o, green_o, blue_o});
    assert ({hsync_o, vsync_o} === 2'b11)
      else flag_mismatch("syncs after reset", 3, {hsync_o, vsync_o});
    assert (score_o === '0) else flag_mismatch("score after reset", 0, score_o);
    assert (gameover_o === 1'b0) else flag_mismatch("gameover after reset", 0, gameover_o);
    while (frame_no < run_frames) begin
      choose_inputs();
      @(posedge clk);
      #1;
      advance_model(1'b0, {drop_btn_i, right_btn_i, left_btn_i}, start_i, fe);
      check_outputs();
      if (fe) frame_no++;
      if (ref_score > max_score) max_score = ref_score;
      if (ref_state == tetris_pkg::state_over) over_seen = 1'b1;
    end
    test_name = "coverage";
    assert (max_score >= 2) else flag_mismatch("peak score", 2, max_score);
    assert (over_seen) else abort_run("game over was never reached");
    $display("test passed");
    $finish;
  end

  // Hard cycle limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      abort_run("simulation ran past the cycle limit");
    end
  end

endmodule

// File: tetris_vga.f
logic/tetris_pkg.sv
logic/button_debounce.sv
logic/drop_timer.sv
logic/playfield.sv
logic/vga_timing.sv
logic/pixel_render.sv
logic/tetris_top.sv
sim/tetris_props.sv
sim/tetris_tb.sv
